// ==== stream_switch.f ====
+incdir+tb
logic/stream_switch_pkg.sv
logic/rr_frame_arbiter.sv
logic/tid_output_stage.sv
logic/stream_switch_top.sv
tb/stream_switch_tb.sv

// ==== tb/stream_switch_tb_model.svh ====
`ifndef stream_switch_tb_model_svh
`define stream_switch_tb_model_svh

// 32-bit xorshift, state lives in the testbench
function automatic logic [31:0] xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

////////////////////////////////////////
// reference arbitration model
////////////////////////////////////////

// whole frames, round robin over sources that still have frames queued
function automatic void build_expected();
    int           pos [num_sources];
    int           start;
    int           src;
    int           cand;
    logic         seen_last;
    tagged_beat_t item;
    exp_q.delete();
    start = 0;
    for (int s = 0; s < num_sources; s++) begin
        pos[s] = 0;
    end
    src = 0;
    while (src >= 0) begin
        src = -1;
        for (int k = 0; k < num_sources; k++) begin
            cand = (start + k) % num_sources;
            if (src < 0 && pos[cand] < src_count[cand]) begin
                src = cand;
            end
        end
        if (src >= 0) begin
            seen_last = 1'b0;
            while (!seen_last) begin
                item.beat = src_mem[src][pos[src]];
                item.tid  = src_idx_t'(src);
                exp_q.push_back(item);
                pos[src]++;
                seen_last = item.beat.last;
            end
            start = (src + 1) % num_sources;
        end
    end
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic compare_beat(input string name, input stream_beat_t got, input stream_beat_t want);
    if (got !== want) begin
        $display("FAIL %s got %h expected %h", name, got, want);
        errors++;
    end
endtask

task automatic compare_tid(input string name, input src_idx_t got, input src_idx_t want);
    if (got !== want) begin
        $display("FAIL %s got %h expected %h", name, got, want);
        errors++;
    end
endtask

task automatic compare_mask(input string name, input src_mask_t got, input src_mask_t want);
    if (got !== want) begin
        $display("FAIL %s got %h expected %h", name, got, want);
        errors++;
    end
endtask

task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("FAIL %s got %h expected %h", name, got, want);
        errors++;
    end
endtask

`endif

// ==== tb/stream_switch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_switch_tb;
    import stream_switch_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int max_beats    = 64;

    logic         axis_clk;
    logic         axi_reset_n;
    src_beats_t   src_beats;
    src_mask_t    src_valid;
    src_mask_t    src_ready;
    tagged_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    // per-source frame storage, walked by the source drivers
    stream_beat_t src_mem [num_sources][max_beats];
    int           src_count [num_sources];
    int           src_pos [num_sources];
    tagged_beat_t exp_q [$];
    logic [31:0]  rng_state = 32'd24;
    logic         running;
    logic         bp_on;
    logic         in_frame;
    src_idx_t     frame_tid;
    int           seen;
    int           errors;
    int           beats_total;
    int           test_num;

    `include "stream_switch_tb_model.svh"

    stream_switch_top u_dut (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .src_beats   (src_beats),
        .src_valid   (src_valid),
        .src_ready   (src_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #(clk_period / 2) axis_clk = ~axis_clk;
    end

    ////////////////////////////////////////
    // source drivers and serdes ready
    ////////////////////////////////////////

    always @(posedge axis_clk) begin
        int nxt;
        if (running) begin
            for (int s = 0; s < num_sources; s++) begin
                nxt = src_pos[s];
                if (src_valid[s] && src_ready[s]) begin
                    nxt++;
                end
                src_pos[s] = nxt;
                if (nxt < src_count[s]) begin
                    src_beats[s] <= src_mem[s][nxt];
                    src_valid[s] <= 1'b1;
                end else begin
                    src_valid[s] <= 1'b0;
                end
            end
        end else begin
            src_valid <= '0;
        end
    end

    // random low periods only while a back-pressure test runs
    always @(posedge axis_clk) begin
        if (running && bp_on) begin
            out_ready <= (xorshift() % 3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // checker
    ////////////////////////////////////////

    always @(posedge axis_clk) begin
        tagged_beat_t want;
        if (axi_reset_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("extra beat with tid %0d after the expected sequence", out_beat.tid);
                errors++;
            end else begin
                want = exp_q.pop_front();
                compare_beat("out_beat.beat", out_beat.beat, want.beat);
                compare_tid("out_beat.tid", out_beat.tid, want.tid);
            end
            if (in_frame && out_beat.tid != frame_tid) begin
                $display("frame lock broken, tid %0d inside a frame of tid %0d",
                         out_beat.tid, frame_tid);
                errors++;
            end
            in_frame  = !out_beat.beat.last;
            frame_tid = out_beat.tid;
            seen++;
        end
    end

    task automatic apply_reset();
        @(posedge axis_clk);
        axi_reset_n <= 1'b0;
        repeat (reset_cycles) @(posedge axis_clk);
        axi_reset_n <= 1'b1;
    endtask

    task automatic clear_sources();
        for (int s = 0; s < num_sources; s++) begin
            src_count[s] = 0;
            src_pos[s]   = 0;
        end
    endtask

    task automatic queue_frames(input int src, input int n_frames, input int min_len,
                                input int max_len);
        int           len;
        logic [31:0]  word;
        stream_beat_t b;
        for (int f = 0; f < n_frames; f++) begin
            len = min_len + int'(xorshift() % (max_len - min_len + 1));
            for (int k = 0; k < len; k++) begin
                b.data = xorshift();
                word   = xorshift();
                b.strb = word[strb_width-1:0];
                b.keep = word[2*strb_width-1:strb_width];
                b.user = word[16 +: user_width];
                b.last = (k == len - 1);
                src_mem[src][src_count[src]] = b;
                src_count[src]++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs, input int beats);
        test_num++;
        beats_total += beats;
        if (errs == 0) begin
            $display("test %0d %s: ok, %0d beats", test_num, name, beats);
        end else begin
            $display("test %0d %s: %0d errors, %0d beats", test_num, name, errs, beats);
        end
    endtask

    task automatic run_frames(input string name, input logic with_bp);
        int total;
        int limit;
        int cycles;
        int err0;
        apply_reset();
        @(negedge axis_clk);
        build_expected();
        total    = exp_q.size();
        limit    = total * 8 + 200;
        seen     = 0;
        in_frame = 1'b0;
        err0     = errors;
        bp_on    = with_bp;
        @(posedge axis_clk);
        running <= 1'b1;
        cycles = 0;
        while (seen < total) begin
            @(negedge axis_clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout in test %s, %0d of %0d beats after %0d cycles",
                         name, seen, total, cycles);
                $display("Regression failed");
                $finish;
            end
        end
        // a few idle cycles to catch stray beats
        repeat (4) @(negedge axis_clk);
        @(posedge axis_clk);
        running <= 1'b0;
        @(negedge axis_clk);
        report_test(name, errors - err0, total);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int err0;
        axi_reset_n = 1'b0;
        src_beats   = '0;
        src_valid   = '0;
        out_ready   = 1'b0;
        running     = 1'b0;
        bp_on       = 1'b0;
        errors      = 0;
        beats_total = 0;
        test_num    = 0;
        clear_sources();
        apply_reset();
        err0 = errors;
        repeat (8) begin
            @(negedge axis_clk);
            compare_flag("out_valid", out_valid, 1'b0);
            compare_mask("src_ready", src_ready, '0);
        end
        report_test("idle after reset", errors - err0, 0);
        clear_sources();
        queue_frames(1, 4, 1, 6);
        run_frames("single source", 1'b0);
        clear_sources();
        for (int s = 0; s < num_sources; s++) begin
            queue_frames(s, 2, 2, 4);
        end
        run_frames("round robin", 1'b0);
        clear_sources();
        for (int s = 0; s < num_sources; s++) begin
            queue_frames(s, 3, 6, 12);
        end
        run_frames("frame lock", 1'b0);
        clear_sources();
        for (int s = 0; s < num_sources; s++) begin
            queue_frames(s, 5, 1, 8);
        end
        run_frames("back-pressure", 1'b1);
        $display("tests %0d, beats checked %0d, errors %0d", test_num, beats_total, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/stream_switch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_switch_top #(
    parameter stream_switch_pkg::src_mask_t src_enable = '1
) (
    input  wire                                axis_clk,
    input  wire                                axi_reset_n,

    // upstream sources
    input  wire stream_switch_pkg::src_beats_t src_beats,
    input  wire stream_switch_pkg::src_mask_t  src_valid,
    output stream_switch_pkg::src_mask_t       src_ready,

    // serdes side
    output stream_switch_pkg::tagged_beat_t    out_beat,
    output logic                               out_valid,
    input  wire                                out_ready
);
    import stream_switch_pkg::*;

    ////////////////////////////////////////
    // arbiter to output stage
    ////////////////////////////////////////

    // one-hot grant and its source number
    src_mask_t grant;
    src_idx_t  grant_idx;

    // back from the output stage
    logic      stage_free;
    logic      frame_done;

    ////////////////////////////////////////
    // frame arbiter
    ////////////////////////////////////////

    rr_frame_arbiter #(
        .src_enable (src_enable)
    ) u_arbiter (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .src_valid   (src_valid),
        .stage_free  (stage_free),
        .frame_done  (frame_done),
        .grant       (grant),
        .grant_idx   (grant_idx),
        .src_ready   (src_ready)
    );

    ////////////////////////////////////////
    // tagged output register
    ////////////////////////////////////////

    tid_output_stage u_output (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .src_beats   (src_beats),
        .src_valid   (src_valid),
        .grant       (grant),
        .grant_idx   (grant_idx),
        .out_ready   (out_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .stage_free  (stage_free),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

// ==== logic/tid_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tid_output_stage (
    input  wire                               axis_clk,
    input  wire                               axi_reset_n,
    input  wire stream_switch_pkg::src_beats_t src_beats,
    input  wire stream_switch_pkg::src_mask_t src_valid,
    input  wire stream_switch_pkg::src_mask_t grant,
    input  wire stream_switch_pkg::src_idx_t  grant_idx,
    input  wire                               out_ready,
    output stream_switch_pkg::tagged_beat_t   out_beat,
    output logic                              out_valid,
    output logic                              stage_free,
    output logic                              frame_done
);
    import stream_switch_pkg::*;

    // beat of the granted source
    stream_beat_t sel_beat;
    logic         sel_valid;

    // beat moves from the source into the output register
    logic         load;

    ////////////////////////////////////////
    // source select
    ////////////////////////////////////////

    assign sel_beat  = src_beats[grant_idx];
    assign sel_valid = |(src_valid & grant);

    // register empty, or its beat leaves this cycle
    assign stage_free = !out_valid || out_ready;

    assign load = sel_valid && stage_free;

    // end of frame seen on the beat being loaded
    assign frame_done = load && sel_beat.last;

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            // accepted with nothing behind it
            out_valid <= 1'b0;
        end
    end

    // payload and tid, held under back-pressure
    always_ff @(posedge axis_clk) begin
        if (load) begin
            out_beat.beat <= sel_beat;
            out_beat.tid  <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rr_frame_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_frame_arbiter #(
    parameter stream_switch_pkg::src_mask_t src_enable = '1
) (
    input  wire                               axis_clk,
    input  wire                               axi_reset_n,
    input  wire stream_switch_pkg::src_mask_t src_valid,
    input  wire                               stage_free,
    input  wire                               frame_done,
    output stream_switch_pkg::src_mask_t      grant,
    output stream_switch_pkg::src_idx_t       grant_idx,
    output stream_switch_pkg::src_mask_t      src_ready
);
    import stream_switch_pkg::*;

    // requests after the enable mask
    src_mask_t req;
    // requests rotated so the round-robin start sits at bit 0
    src_mask_t req_rot;
    // lowest set bit of the rotated requests
    src_mask_t pick_rot;
    src_mask_t grant_next;
    src_idx_t  idx_next;
    logic      any_req;

    // round-robin start and frame lock
    src_idx_t  rr_start;
    src_idx_t  rr_after;
    logic      frame_lock;

    ////////////////////////////////////////
    // request rotation and pick
    ////////////////////////////////////////

    assign req = src_valid & src_enable;

    always_comb begin
        int pos;
        req_rot = '0;
        for (int k = 0; k < num_sources; k++) begin
            pos        = (k + rr_start) % num_sources;
            req_rot[k] = req[pos];
        end
    end

    assign any_req = |req_rot;

    // isolate lowest set bit
    assign pick_rot = req_rot & (~req_rot + 1'b1);

    // rotate the pick back into source order
    always_comb begin
        int pos;
        grant_next = '0;
        idx_next   = '0;
        for (int k = 0; k < num_sources; k++) begin
            pos = (k + rr_start) % num_sources;
            if (pick_rot[k]) begin
                grant_next[pos] = 1'b1;
                idx_next        = src_idx_t'(pos);
            end
        end
    end

    // next start is the source after the one just served
    assign rr_after = (grant_idx == src_idx_t'(num_sources - 1)) ? '0
                                                                 : grant_idx + 1'b1;

    ////////////////////////////////////////
    // grant register
    ////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            grant      <= '0;
            grant_idx  <= '0;
            frame_lock <= 1'b0;
            rr_start   <= '0;
        end else if (!frame_lock) begin
            // idle, take the first requester at or after the start
            if (any_req) begin
                grant      <= grant_next;
                grant_idx  <= idx_next;
                frame_lock <= 1'b1;
            end
        end else if (frame_done) begin
            // last beat taken, release and move the start on
            grant      <= '0;
            frame_lock <= 1'b0;
            rr_start   <= rr_after;
        end
    end

    // ready only to the granted source while the stage can take a beat
    assign src_ready = grant & {num_sources{stage_free}};

endmodule

`default_nettype wire

// ==== logic/stream_switch_pkg.sv ====
`default_nettype none

package stream_switch_pkg;

    ////////////////////////////////////////
    // stream widths
    ////////////////////////////////////////

    // payload and byte lanes
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // sideband fields carried with every beat
    localparam int user_width = 2;
    localparam int tid_width  = 2;

    // upstream sources sharing the serdes stream
    localparam int num_sources = 3;

    ////////////////////////////////////////
    // source numbering
    ////////////////////////////////////////

    // source number, doubles as the outgoing tid
    typedef logic [tid_width-1:0] src_idx_t;

    // one bit per source: requests, grants, enables
    typedef logic [num_sources-1:0] src_mask_t;

    ////////////////////////////////////////
    // beat types
    ////////////////////////////////////////

    // one axi-stream beat as seen on a source port
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [strb_width-1:0] keep;
        logic                  last;
        logic [user_width-1:0] user;
    } stream_beat_t;

    // beat on the serdes side, tagged with the source it came from
    typedef struct packed {
        stream_beat_t beat;
        src_idx_t     tid;
    } tagged_beat_t;

    // all source beats side by side, index = source number
    typedef stream_beat_t [num_sources-1:0] src_beats_t;

endpackage

`default_nettype wire
